/* hw/uart_frame_pkg.sv */
`default_nettype none

package uart_frame_pkg;

    // system clock in hertz
    localparam logic [31:0] CLK_FREQ  = 32'd25_000_000;
    localparam logic [31:0] BAUD_RATE = 32'd390_625;

    // ticks per serial bit
    localparam logic [4:0] OVERSAMPLE = 5'd16;

    // clk cycles per oversampling tick
    localparam logic [11:0] BAUD_DIV = 12'(CLK_FREQ / (BAUD_RATE * OVERSAMPLE));

    // receiver samples on this tick of each bit
    localparam logic [4:0] MID_TICK = 5'd8;

    localparam logic [3:0] MAX_DATA_BITS = 4'd8;

    // code n selects n+5 data bits
    typedef logic [1:0] data_len_t;

endpackage

`default_nettype wire

/* hw/apb_map_pkg.sv */
`default_nettype none

package apb_map_pkg;

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    localparam logic [ADDR_W-1:0] ADDR_TXDATA = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_RXDATA = 12'h004;
    localparam logic [ADDR_W-1:0] ADDR_CFG    = 12'h008;
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 12'h00C;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 12'h010;

    // config register fields
    localparam int CFG_LEN_LSB     = 0;
    localparam int CFG_STOP2_BIT   = 2;
    localparam int CFG_PAR_EN_BIT  = 3;
    localparam int CFG_PAR_ODD_BIT = 4;

    localparam int CTRL_START_BIT = 0;

    // status register fields
    localparam int STAT_TX_BUSY_BIT  = 0;
    localparam int STAT_RX_VALID_BIT = 1;
    localparam int STAT_PAR_ERR_BIT  = 2;

endpackage

`default_nettype wire

/* hw/baud_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen import uart_frame_pkg::*; (
    input  wire  clk,
    input  wire  reset_n,
    input  wire  restart_i,
    output logic tick_o
);

    logic [11:0] div_cnt;

    // first tick comes BAUD_DIV cycles after restart drops
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            tick_o  <= 1'b0;
        end else if (restart_i) begin
            div_cnt <= '0;
            tick_o  <= 1'b0;
        end else if (div_cnt == BAUD_DIV - 12'd1) begin
            div_cnt <= '0;
            tick_o  <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 12'd1;
            tick_o  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/apb_uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_uart_regs import apb_map_pkg::*, uart_frame_pkg::*; (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      psel_i,
    input  wire                      penable_i,
    input  wire                      pwrite_i,
    input  wire  [ADDR_W-1:0]        paddr_i,
    input  wire  [DATA_W-1:0]        pwdata_i,
    output logic [DATA_W-1:0]        prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    output logic                     tx_start_o,
    output logic [MAX_DATA_BITS-1:0] tx_data_o,
    output data_len_t                data_len_o,
    output logic                     stop2_o,
    output logic                     par_en_o,
    output logic                     par_odd_o,
    input  wire                      tx_busy_i,
    input  wire                      rx_valid_i,
    input  wire  [MAX_DATA_BITS-1:0] rx_data_i,
    input  wire                      rx_par_err_i,
    output logic                     rts_n_o
);

    logic [MAX_DATA_BITS-1:0]   txdata_q;
    logic [MAX_DATA_BITS-1:0]   rxdata_q;
    logic [CFG_PAR_ODD_BIT:0]   cfg_q;
    logic                       rx_valid_q;
    logic                       par_err_q;
    logic [DATA_W-1:0]          rd_data;
    logic                       addr_ok;
    logic                       read_only;
    logic                       access;
    logic                       wr_en;
    logic                       rd_rxdata;

    always_comb begin
        rd_data   = '0;
        addr_ok   = 1'b1;
        read_only = 1'b0;
        case (paddr_i)
            ADDR_TXDATA: rd_data[MAX_DATA_BITS-1:0] = txdata_q;
            ADDR_RXDATA: begin
                rd_data[MAX_DATA_BITS-1:0] = rxdata_q;
                read_only                  = 1'b1;
            end
            ADDR_CFG:    rd_data[CFG_PAR_ODD_BIT:0] = cfg_q;
            // start bit is a strobe only
            ADDR_CTRL:   rd_data = '0;
            ADDR_STATUS: begin
                rd_data[STAT_TX_BUSY_BIT]  = tx_busy_i;
                rd_data[STAT_RX_VALID_BIT] = rx_valid_q;
                rd_data[STAT_PAR_ERR_BIT]  = par_err_q;
                read_only                  = 1'b1;
            end
            default:     addr_ok = 1'b0;
        endcase
    end

    assign access    = psel_i & penable_i;
    assign pslverr_o = access & (~addr_ok | (pwrite_i & read_only));
    assign wr_en     = access & pwrite_i & ~pslverr_o;
    assign rd_rxdata = access & ~pwrite_i & (paddr_i == ADDR_RXDATA);
    assign prdata_o  = (access & ~pwrite_i) ? rd_data : '0;
    assign pready_o  = 1'b1;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            txdata_q   <= '0;
            cfg_q      <= '0;
            tx_start_o <= 1'b0;
            rxdata_q   <= '0;
            rx_valid_q <= 1'b0;
            par_err_q  <= 1'b0;
        end else begin
            if (wr_en && paddr_i == ADDR_TXDATA) begin
                txdata_q <= pwdata_i[MAX_DATA_BITS-1:0];
            end
            if (wr_en && paddr_i == ADDR_CFG) begin
                cfg_q <= pwdata_i[CFG_PAR_ODD_BIT:0];
            end
            tx_start_o <= wr_en && paddr_i == ADDR_CTRL && pwdata_i[CTRL_START_BIT];
            // a new frame wins over a read in the same cycle
            if (rx_valid_i) begin
                rxdata_q   <= rx_data_i;
                par_err_q  <= rx_par_err_i;
                rx_valid_q <= 1'b1;
            end else if (rd_rxdata) begin
                rx_valid_q <= 1'b0;
            end
        end
    end

    assign tx_data_o  = txdata_q;
    assign data_len_o = cfg_q[CFG_LEN_LSB +: 2];
    assign stop2_o    = cfg_q[CFG_STOP2_BIT];
    assign par_en_o   = cfg_q[CFG_PAR_EN_BIT];
    assign par_odd_o  = cfg_q[CFG_PAR_ODD_BIT];
    assign rts_n_o    = rx_valid_q;

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_frame_pkg::*; (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      start_i,
    input  wire  [MAX_DATA_BITS-1:0] data_i,
    input  data_len_t                data_len_i,
    input  wire                      stop2_i,
    input  wire                      par_en_i,
    input  wire                      par_odd_i,
    input  wire                      cts_n_i,
    output logic                     busy_o,
    output logic                     tx_o
);

    typedef enum logic [2:0] {TX_IDLE, TX_WAIT, TX_START, TX_DATA, TX_PAR, TX_STOP} tx_state_t;

    tx_state_t                  state;
    logic                       tick;
    logic                       bit_end;
    logic [4:0]                 tick_cnt;
    logic [3:0]                 bit_cnt;
    logic                       stop_cnt;
    logic [MAX_DATA_BITS-1:0]   shift_q;
    logic [MAX_DATA_BITS-1:0]   masked;
    data_len_t                  len_q;
    logic                       stop2_q;
    logic                       par_en_q;
    logic                       par_q;
    logic                       accept;

    baud_tick_gen u_tick (
        .clk       (clk),
        .reset_n   (reset_n),
        .restart_i (state == TX_IDLE || state == TX_WAIT),
        .tick_o    (tick)
    );

    assign accept  = (state == TX_IDLE) && start_i;
    assign bit_end = tick && (tick_cnt == OVERSAMPLE - 5'd1);
    // parity only covers the active data bits
    assign masked  = data_i & (8'hFF >> (2'd3 - data_len_i));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
        end else begin
            if (state == TX_IDLE || state == TX_WAIT) begin
                tick_cnt <= '0;
            end else if (tick) begin
                tick_cnt <= bit_end ? 5'd0 : tick_cnt + 5'd1;
            end
            case (state)
                TX_IDLE: begin
                    if (start_i) begin
                        state    <= cts_n_i ? TX_WAIT : TX_START;
                        stop_cnt <= 1'b0;
                    end
                end
                TX_WAIT:  if (!cts_n_i) state <= TX_START;
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == {2'b00, len_q} + 4'd4) begin
                            state <= par_en_q ? TX_PAR : TX_STOP;
                        end
                    end
                end
                TX_PAR:   if (bit_end) state <= TX_STOP;
                TX_STOP: begin
                    if (bit_end) begin
                        if (stop2_q && !stop_cnt) stop_cnt <= 1'b1;
                        else state <= TX_IDLE;
                    end
                end
                default:  state <= TX_IDLE;
            endcase
        end
    end

    // frame contents latched when the strobe is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q  <= data_i;
            len_q    <= data_len_i;
            stop2_q  <= stop2_i;
            par_en_q <= par_en_i;
            par_q    <= (^masked) ^ par_odd_i;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state)
            TX_START: tx_o = 1'b0;
            TX_DATA:  tx_o = shift_q[0];
            TX_PAR:   tx_o = par_q;
            default:  tx_o = 1'b1;
        endcase
    end

    assign busy_o = (state != TX_IDLE);

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_frame_pkg::*; (
    input  wire                      clk,
    input  wire                      reset_n,
    input  data_len_t                data_len_i,
    input  wire                      par_en_i,
    input  wire                      par_odd_i,
    input  wire                      rx_i,
    output logic                     valid_o,
    output logic [MAX_DATA_BITS-1:0] data_o,
    output logic                     par_err_o
);

    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PAR, RX_STOP} rx_state_t;

    rx_state_t                  state;
    logic                       rx_meta;
    logic                       rx_sync;
    logic                       rx_prev;
    logic                       tick;
    logic                       mid;
    logic                       bit_end;
    logic [4:0]                 tick_cnt;
    logic [3:0]                 bit_cnt;
    logic [MAX_DATA_BITS-1:0]   shift_q;

    // tick counter restarts on the start edge
    baud_tick_gen u_tick (
        .clk       (clk),
        .reset_n   (reset_n),
        .restart_i (state == RX_IDLE),
        .tick_o    (tick)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // sample on the MID_TICK-th tick of each bit
    assign mid     = tick && (tick_cnt == MID_TICK - 5'd1);
    assign bit_end = tick && (tick_cnt == OVERSAMPLE - 5'd1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            valid_o   <= 1'b0;
            par_err_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (state == RX_IDLE) begin
                tick_cnt <= '0;
            end else if (tick) begin
                tick_cnt <= bit_end ? 5'd0 : tick_cnt + 5'd1;
            end
            case (state)
                RX_IDLE:  if (rx_prev && !rx_sync) state <= RX_START;
                RX_START: begin
                    // glitch rather than a real start bit
                    if (mid && rx_sync) begin
                        state <= RX_IDLE;
                    end else if (bit_end) begin
                        state     <= RX_DATA;
                        bit_cnt   <= '0;
                        par_err_o <= 1'b0;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == {2'b00, data_len_i} + 4'd4) begin
                            state <= par_en_i ? RX_PAR : RX_STOP;
                        end
                    end
                end
                RX_PAR: begin
                    if (mid) par_err_o <= ((^data_o) ^ rx_sync) != par_odd_i;
                    if (bit_end) state <= RX_STOP;
                end
                RX_STOP: begin
                    if (mid) begin
                        valid_o <= 1'b1;
                        state   <= RX_IDLE;
                    end
                end
                default:  state <= RX_IDLE;
            endcase
        end
    end

    // lsb first entering at the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && mid) begin
            shift_q <= {rx_sync, shift_q[MAX_DATA_BITS-1:1]};
        end
    end

    // short frames sit high in the shifter
    assign data_o = shift_q >> (2'd3 - data_len_i);

endmodule

`default_nettype wire

/* hw/apb_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_uart_top import apb_map_pkg::*, uart_frame_pkg::*; (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               psel_i,
    input  wire               penable_i,
    input  wire               pwrite_i,
    input  wire  [ADDR_W-1:0] paddr_i,
    input  wire  [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output logic              tx_o,
    input  wire               rx_i,
    input  wire               cts_n_i,
    output logic              rts_n_o
);

    logic                       tx_start;
    logic [MAX_DATA_BITS-1:0]   tx_data;
    data_len_t                  data_len;
    logic                       stop2;
    logic                       par_en;
    logic                       par_odd;
    logic                       tx_busy;
    logic                       rx_valid;
    logic [MAX_DATA_BITS-1:0]   rx_data;
    logic                       rx_par_err;

    apb_uart_regs u_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .tx_start_o   (tx_start),
        .tx_data_o    (tx_data),
        .data_len_o   (data_len),
        .stop2_o      (stop2),
        .par_en_o     (par_en),
        .par_odd_o    (par_odd),
        .tx_busy_i    (tx_busy),
        .rx_valid_i   (rx_valid),
        .rx_data_i    (rx_data),
        .rx_par_err_i (rx_par_err),
        .rts_n_o      (rts_n_o)
    );

    uart_tx u_tx (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (tx_start),
        .data_i     (tx_data),
        .data_len_i (data_len),
        .stop2_i    (stop2),
        .par_en_i   (par_en),
        .par_odd_i  (par_odd),
        .cts_n_i    (cts_n_i),
        .busy_o     (tx_busy),
        .tx_o       (tx_o)
    );

    uart_rx u_rx (
        .clk        (clk),
        .reset_n    (reset_n),
        .data_len_i (data_len),
        .par_en_i   (par_en),
        .par_odd_i  (par_odd),
        .rx_i       (rx_i),
        .valid_o    (rx_valid),
        .data_o     (rx_data),
        .par_err_o  (rx_par_err)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    localparam real HALF_PERIOD = 20.0;

    initial clk = 1'b0;

    // 40 ns period
    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

/* tb/tb_apb_uart.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apb_uart
    import apb_map_pkg::*, uart_frame_pkg::*;
();

    localparam int TX_FRAMES  = 5;
    localparam int RX_FRAMES  = 6;
    localparam int BIT_CYCLES = 64;
    // 12 bits per frame plus room for bus traffic and the cts wait
    localparam int WATCHDOG_CYCLES = (TX_FRAMES + RX_FRAMES + 3) * 12 * BIT_CYCLES + 3000;

    logic              clk;
    logic              reset_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              tx;
    logic              rx;
    logic              cts_n;
    logic              rts_n;
    integer            seed;
    int                cyc = 0;

    tb_clk_gen u_clk (
        .clk (clk)
    );

    apb_uart_top DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .tx_o      (tx),
        .rx_i      (rx),
        .cts_n_i   (cts_n),
        .rts_n_o   (rts_n)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic expect_ok(input bit cond, input string msg);
        assert (cond) else begin
            $display("[FAIL] %0t ns: %s", $time, msg);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first failed check");
        end
    endtask

    // two-cycle transfer sampled mid access
    task automatic transfer(input bit wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic slverr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata  = prdata;
        slverr = pslverr;
        expect_ok(pready == 1'b1, "pready low in access phase");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        logic              slverr;
        transfer(1'b1, addr, data, unused, slverr);
        expect_ok(!slverr, $sformatf("pslverr on write to 0x%03h", addr));
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        logic slverr;
        transfer(1'b0, addr, '0, data, slverr);
        expect_ok(!slverr, $sformatf("pslverr on read of 0x%03h", addr));
    endtask

    task automatic wait_until(input int target);
        @(negedge clk);
        while (cyc < target) @(negedge clk);
    endtask

    task automatic pick_frame(output logic [7:0] data, output logic [4:0] cfg);
        logic [31:0] rnd;
        rnd  = $random(seed);
        data = rnd[7:0];
        cfg  = rnd[12:8];
    endtask

    // start, data, optional parity, stop bits
    function automatic int frame_len(input logic [4:0] cfg);
        return 1 + int'(cfg[1:0]) + 5 + int'(cfg[3]) + (cfg[2] ? 2 : 1);
    endfunction

    // bit i of the result goes on the line in bit period i
    function automatic logic [11:0] frame_bits(input logic [7:0] data, input logic [4:0] cfg,
                                               input bit flip_par);
        logic [11:0] bits;
        logic        ones;
        int          nd;
        bits    = '1;
        bits[0] = 1'b0;
        ones    = 1'b0;
        nd      = int'(cfg[1:0]) + 5;
        for (int j = 0; j < nd; j++) begin
            bits[1 + j] = data[j];
            ones        = ones ^ data[j];
        end
        if (cfg[3]) bits[1 + nd] = ones ^ cfg[4] ^ flip_par;
        return bits;
    endfunction

    function automatic logic [7:0] masked_data(input logic [7:0] data, input logic [4:0] cfg);
        logic [7:0] out;
        out = '0;
        for (int j = 0; j < int'(cfg[1:0]) + 5; j++) out[j] = data[j];
        return out;
    endfunction

    task automatic drive_bit(input logic b);
        @(posedge clk);
        rx <= b;
        repeat (BIT_CYCLES - 1) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic [4:0] cfg, input bit flip_par);
        logic [11:0] bits;
        int          n;
        bits = frame_bits(data, cfg, flip_par);
        n    = frame_len(cfg);
        for (int i = 0; i < n; i++) drive_bit(bits[i]);
    endtask

    // called at the first negedge inside the start bit
    task automatic verify_tx_frame(input logic [7:0] data, input logic [4:0] cfg);
        int                t0;
        int                n;
        logic [11:0]       bits;
        logic [DATA_W-1:0] st;
        t0   = cyc;
        n    = frame_len(cfg);
        bits = frame_bits(data, cfg, 1'b0);
        read_reg(ADDR_STATUS, st);
        expect_ok(st[STAT_TX_BUSY_BIT] == 1'b1, "STATUS busy low during a frame");
        for (int i = 0; i < n; i++) begin
            wait_until(t0 + BIT_CYCLES / 2 + i * BIT_CYCLES);
            expect_ok(tx == bits[i], $sformatf("tx bit %0d of data 0x%02h cfg 0x%02h is %b",
                                               i, data, cfg, tx));
        end
        wait_until(t0 + n * BIT_CYCLES + 8);
        read_reg(ADDR_STATUS, st);
        expect_ok(st[STAT_TX_BUSY_BIT] == 1'b0, "STATUS busy still set after the frame");
        expect_ok(tx == 1'b1, "tx not idle after the frame");
    endtask

    task automatic check_rx(input logic [7:0] data, input logic [4:0] cfg, input bit par_err);
        logic [DATA_W-1:0] rd;
        read_reg(ADDR_STATUS, rd);
        expect_ok(rd[STAT_RX_VALID_BIT] == 1'b1, "STATUS valid low after a frame");
        expect_ok(rd[STAT_PAR_ERR_BIT] == par_err, $sformatf("parity error flag is %b",
                                                             rd[STAT_PAR_ERR_BIT]));
        @(negedge clk);
        expect_ok(rts_n == 1'b1, "rts_n low while a byte waits");
        read_reg(ADDR_RXDATA, rd);
        expect_ok(rd == {24'h0, masked_data(data, cfg)},
                  $sformatf("RXDATA 0x%0h, sent 0x%02h with cfg 0x%02h", rd, data, cfg));
        @(negedge clk);
        expect_ok(rts_n == 1'b0, "rts_n high after RXDATA read");
        read_reg(ADDR_STATUS, rd);
        expect_ok(rd[STAT_RX_VALID_BIT] == 1'b0, "STATUS valid not cleared by the read");
    endtask

    initial begin
        logic [7:0]        data;
        logic [4:0]        cfg;
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] rd_prev;
        logic [DATA_W-1:0] word;
        logic              err;
        seed    = 32'haf6f_54b4;
        reset_n = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rx      = 1'b1;
        cts_n   = 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        @(negedge clk);
        expect_ok(tx == 1'b1, "tx not high after reset");
        expect_ok(rts_n == 1'b0, "rts_n not low after reset");
        read_reg(ADDR_STATUS, rd);
        expect_ok(rd == '0, "STATUS not 0 after reset");
        read_reg(ADDR_CFG, rd);
        expect_ok(rd == '0, "CFG not 0 after reset");
        read_reg(ADDR_TXDATA, rd);
        expect_ok(rd == '0, "TXDATA not 0 after reset");

        word = $random(seed);
        write_reg(ADDR_CFG, word);
        read_reg(ADDR_CFG, rd);
        expect_ok(rd[4:0] == word[4:0], $sformatf("CFG reads 0x%0h after 0x%0h", rd, word));
        // bit 0 clear so no frame starts
        write_reg(ADDR_CTRL, 32'hFFFF_FFFE);
        read_reg(ADDR_CTRL, rd);
        expect_ok(rd == '0, "CTRL does not read 0");
        transfer(1'b0, 12'h020, '0, rd, err);
        expect_ok(err, "no pslverr on unmapped read");
        read_reg(ADDR_RXDATA, rd_prev);
        transfer(1'b1, ADDR_RXDATA, 32'h0000_005A, rd, err);
        expect_ok(err, "no pslverr on write to RXDATA");
        read_reg(ADDR_RXDATA, rd);
        expect_ok(rd == rd_prev, "RXDATA changed by a rejected write");

        for (int k = 0; k < TX_FRAMES; k++) begin
            pick_frame(data, cfg);
            write_reg(ADDR_TXDATA, {24'h0, data});
            write_reg(ADDR_CFG, {27'h0, cfg});
            write_reg(ADDR_CTRL, 32'h1);
            @(negedge clk);
            expect_ok(tx == 1'b1, "start bit during the strobe cycle");
            @(negedge clk);
            expect_ok(tx == 1'b0, "start bit missing one cycle after the strobe");
            verify_tx_frame(data, cfg);
        end

        // cts gating
        pick_frame(data, cfg);
        write_reg(ADDR_TXDATA, {24'h0, data});
        write_reg(ADDR_CFG, {27'h0, cfg});
        @(posedge clk);
        cts_n <= 1'b1;
        write_reg(ADDR_CTRL, 32'h1);
        repeat (200) begin
            @(negedge clk);
            expect_ok(tx == 1'b1, "tx left idle while cts_n high");
        end
        read_reg(ADDR_STATUS, rd);
        expect_ok(rd[STAT_TX_BUSY_BIT] == 1'b1, "STATUS busy low while waiting for cts");
        @(posedge clk);
        cts_n <= 1'b0;
        @(negedge clk);
        expect_ok(tx == 1'b1, "start bit before cts_n was seen low");
        @(negedge clk);
        expect_ok(tx == 1'b0, "no start bit after cts_n went low");
        verify_tx_frame(data, cfg);

        for (int k = 0; k < RX_FRAMES; k++) begin
            pick_frame(data, cfg);
            write_reg(ADDR_CFG, {27'h0, cfg});
            send_frame(data, cfg, 1'b0);
            check_rx(data, cfg, 1'b0);
        end

        // wrong parity bit then a clean frame
        pick_frame(data, cfg);
        cfg[3] = 1'b1;
        write_reg(ADDR_CFG, {27'h0, cfg});
        send_frame(data, cfg, 1'b1);
        check_rx(data, cfg, 1'b1);
        pick_frame(data, cfg);
        cfg[3] = 1'b1;
        write_reg(ADDR_CFG, {27'h0, cfg});
        send_frame(data, cfg, 1'b0);
        check_rx(data, cfg, 1'b0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error: watchdog expired after %0d cycles, the test did not finish",
                 WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

/* build.f */
hw/uart_frame_pkg.sv
hw/apb_map_pkg.sv
hw/baud_tick_gen.sv
hw/apb_uart_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/apb_uart_top.sv
tb/tb_clk_gen.sv
tb/tb_apb_uart.sv

/* Bender.yml */
package:
  name: apb_uart

sources:
  - hw/uart_frame_pkg.sv
  - hw/apb_map_pkg.sv
  - hw/baud_tick_gen.sv
  - hw/apb_uart_regs.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/apb_uart_top.sv
  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_apb_uart.sv
